/* zx_mem_top.f */
source/zx_mem_pkg.sv
source/zx_video_pkg.sv
source/cpu_window_mapper.sv
source/video_line_fetch.sv
source/dram_slot_arbiter.sv
source/dram_store.sv
source/zx_mem_top.sv
testbench/zx_mem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log
TOP=zx_mem_tb

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

verilator --binary --timing -Wno-fatal --top-module "$TOP" \
	-f zx_mem_top.f --Mdir "$OBJ_DIR" -o zx_mem_sim
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

"./$OBJ_DIR/zx_mem_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "=== PASS ===" "$LOG"; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed, see $LOG"
exit 1

/* testbench/zx_mem_tb.sv */
`timescale 1ns/1ns

module zx_mem_tb
	import zx_mem_pkg::*, zx_video_pkg::*;
();

	localparam int WAIT_LIMIT = 200;

	typedef enum logic [1:0] {k_page, k_write, k_read, k_line} kind_t;

	// one row of the stimulus table
	typedef struct packed {
		kind_t      kind;
		logic [1:0] win;
		page_t      page;
		cpu_addr_t  addr;
		logic [7:0] data;
		logic [7:0] exp;
	} step_t;

	logic        fclk;
	logic        rst_n;
	logic        cpu_valid;
	logic        cpu_rnw;
	cpu_addr_t   cpu_addr;
	logic [7:0]  cpu_wdata;
	logic        cpu_ready;
	logic        cpu_rdata_valid;
	logic [7:0]  cpu_rdata;
	logic        pg_wr;
	logic [1:0]  pg_win;
	page_t       pg_val;
	logic        line_start;
	line_t       line_num;
	logic        pix_valid;
	word_idx_t   pix_idx;
	mem_word_t   pix_word;

	step_t       steps [$];
	// reference memory, keyed by aliased byte address
	logic [7:0]  ref_mem [int unsigned];
	page_t       ref_page [4];
	logic [7:0]  rd_exp [$];
	mem_word_t   vid_exp [$];

	logic [31:0] lfsr_state;
	int          inflight;
	int          vid_pending;
	int          vid_idx;
	int          ready_drops;
	int          checks;
	int          mismatches;
	int          failures;
	logic        exp_ready;
	logic [7:0]  exp_byte;
	mem_word_t   exp_word;

	zx_mem_top uut (.*);

	initial fclk = 1'b0;
	always #50 fclk = ~fclk;

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	// galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// only the low STORE_AW word bits reach the store
	function automatic int unsigned byte_key(input phys_addr_t w, input logic lane);
		logic [31:0] k;
		k = '0;
		k[STORE_AW:0] = {w[STORE_AW-1:0], lane};
		return k;
	endfunction

	function automatic phys_addr_t cpu_word(input cpu_addr_t a);
		return {ref_page[a[15:14]], a[13:1]};
	endfunction

	task automatic report_mismatch(input string name, input logic [15:0] exp,
		input logic [15:0] act);
		$display("MISMATCH time %0t: %s expected %h, got %h", $time, name, exp, act);
		mismatches++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// table building, model runs alongside
	////////////////////////////////////////////////////////////////////////////

	task automatic add_page(input logic [1:0] win, input page_t pg);
		step_t s;
		s = '{kind: k_page, win: win, page: pg, addr: '0, data: '0, exp: '0};
		ref_page[win] = pg;
		steps.push_back(s);
	endtask

	task automatic add_write(input cpu_addr_t a, input logic [7:0] d);
		step_t s;
		s = '{kind: k_write, win: a[15:14], page: '0, addr: a, data: d, exp: '0};
		ref_mem[byte_key(cpu_word(a), a[0])] = d;
		steps.push_back(s);
	endtask

	task automatic add_read(input cpu_addr_t a);
		step_t       s;
		int unsigned key;
		key = byte_key(cpu_word(a), a[0]);
		s = '{kind: k_read, win: a[15:14], page: '0, addr: a, data: '0, exp: '0};
		if (!ref_mem.exists(key))
		begin
			$display("stimulus table reads address %h before writing it", a);
			failures++;
		end
		else
			s.exp = ref_mem[key];
		steps.push_back(s);
	endtask

	task automatic add_line(input line_t ln);
		step_t                s;
		logic [WIN_OFF_W-1:0] off;
		phys_addr_t           w;
		int unsigned          lo;
		int unsigned          hi;
		for (int i = 0; i < WORDS_PER_LINE; i++)
		begin
			off = WIN_OFF_W'(int'(ln) * WORDS_PER_LINE + i);
			w   = {VIDEO_PAGE, off};
			lo  = byte_key(w, 1'b0);
			hi  = byte_key(w, 1'b1);
			if (!ref_mem.exists(lo) || !ref_mem.exists(hi))
			begin
				$display("stimulus table fetches screen line %0d before writing it", ln);
				failures++;
				vid_exp.push_back('0);
			end
			else
				vid_exp.push_back({ref_mem[hi], ref_mem[lo]});
		end
		s = '{kind: k_line, win: 2'd0, page: VIDEO_PAGE, addr: '0, data: ln, exp: '0};
		steps.push_back(s);
	endtask

	task automatic build_table();
		cpu_addr_t a;
		int        ln;
		int        off;
		// reset mapping, one byte per window
		for (int w = 0; w < 4; w++)
		begin
			a = 16'(w * 'h4000 + 'h100 + w * 17);
			add_write(a, 8'(take_bits(8)));
			add_read(a);
		end
		// windows 1 and 2 share a page, window 3 has its own
		add_page(2'd1, 8'h20);
		add_page(2'd2, 8'h20);
		add_page(2'd3, 8'h33);
		add_write(16'h4456, 8'ha5);
		add_write(16'hc460, 8'h3c);
		add_read(16'h8456);
		add_read(16'hc460);
		add_read(16'h4456);
		// adjacent lanes of one word
		add_write(16'h0200, 8'h11);
		add_write(16'h0201, 8'h22);
		add_read(16'h0200);
		add_read(16'h0201);
		add_write(16'h0200, 8'hee);
		add_read(16'h0201);
		add_read(16'h0200);
		// screen lines 3 and 7 through window 1
		add_page(2'd1, VIDEO_PAGE);
		for (int j = 0; j < 2 * WORDS_PER_LINE; j++)
		begin
			add_write(16'('h4000 + 3 * 32 + j), 8'(take_bits(8)));
			add_write(16'('h4000 + 7 * 32 + j), 8'(take_bits(8)));
		end
		add_line(8'd3);
		// back to back reads while line 7 is fetched
		add_line(8'd7);
		for (int r = 0; r < 12; r++)
		begin
			ln  = take_bits(1) ? 7 : 3;
			off = int'(take_bits(5));
			a   = 16'('h4000 + ln * 32 + off);
			add_read(a);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// drivers
	////////////////////////////////////////////////////////////////////////////

	task automatic tick_idle();
		@(posedge fclk);
		cpu_valid  <= 1'b0;
		pg_wr      <= 1'b0;
		line_start <= 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		for (int i = 0; i < n; i++)
			tick_idle();
	endtask

	task automatic page_write(input step_t s);
		@(posedge fclk);
		cpu_valid  <= 1'b0;
		line_start <= 1'b0;
		pg_wr      <= 1'b1;
		pg_win     <= s.win;
		pg_val     <= s.page;
	endtask

	// valid stays up until the next drive
	task automatic cpu_access(input step_t s);
		int waited;
		waited = 0;
		@(posedge fclk);
		cpu_valid  <= 1'b1;
		cpu_rnw    <= (s.kind == k_read);
		cpu_addr   <= s.addr;
		cpu_wdata  <= s.data;
		pg_wr      <= 1'b0;
		line_start <= 1'b0;
		@(negedge fclk);
		while (!cpu_ready && waited < WAIT_LIMIT)
		begin
			@(negedge fclk);
			waited++;
		end
		if (!cpu_ready)
		begin
			$display("time %0t: cpu access to %h was never accepted", $time, s.addr);
			failures++;
		end
		else if (s.kind == k_read)
			rd_exp.push_back(s.exp);
	endtask

	task automatic start_line(input step_t s);
		int waited;
		waited = 0;
		tick_idle();
		// earlier burst done and screen bytes issued to the store
		while ((vid_pending != 0 || inflight != 0) && waited < WAIT_LIMIT)
		begin
			tick_idle();
			waited++;
		end
		if (vid_pending != 0 || inflight != 0)
		begin
			$display("time %0t: memory never went idle before line %0d", $time, s.data);
			failures++;
		end
		else
		begin
			@(posedge fclk);
			line_start <= 1'b1;
			line_num   <= s.data;
			vid_pending += WORDS_PER_LINE;
			tick_idle();
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		tick_idle();
		while ((rd_exp.size() != 0 || vid_pending != 0) && waited < WAIT_LIMIT)
		begin
			tick_idle();
			waited++;
		end
		if (rd_exp.size() != 0 || vid_pending != 0)
		begin
			$display("time %0t: %0d cpu reads and %0d screen words never came back",
				$time, rd_exp.size(), vid_pending);
			failures++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// monitor, mid cycle
	////////////////////////////////////////////////////////////////////////////

	always @(negedge fclk)
	begin
		if (rst_n)
		begin
			// credits held by the mapper follow accepts and issue pulses
			exp_ready = (inflight < REQ_CREDITS);
			checks++;
			if (cpu_ready !== exp_ready)
				report_mismatch("cpu_ready", 16'(exp_ready), 16'(cpu_ready));
			if (inflight > REQ_CREDITS)
			begin
				$display("time %0t: %0d cpu accesses outstanding, above the credit limit",
					$time, inflight);
				failures++;
			end
			if (!cpu_ready)
				ready_drops++;
			inflight = inflight + int'(cpu_valid && cpu_ready) - int'(uut.cpu_credit);

			if (cpu_rdata_valid)
			begin
				if (rd_exp.size() == 0)
				begin
					$display("time %0t: cpu read data came back with no read outstanding",
						$time);
					failures++;
				end
				else
				begin
					exp_byte = rd_exp.pop_front();
					checks++;
					if (cpu_rdata !== exp_byte)
						report_mismatch("cpu_rdata", 16'(exp_byte), 16'(cpu_rdata));
				end
			end

			if (pix_valid)
			begin
				if (vid_pending == 0 || vid_exp.size() == 0)
				begin
					$display("time %0t: screen word arrived with no line running", $time);
					failures++;
				end
				else
				begin
					exp_word = vid_exp.pop_front();
					checks += 2;
					if (pix_idx !== word_idx_t'(vid_idx))
						report_mismatch("pix_idx", 16'(vid_idx), 16'(pix_idx));
					if (pix_word !== exp_word)
						report_mismatch("pix_word", exp_word, pix_word);
					vid_idx = (vid_idx + 1) % WORDS_PER_LINE;
					vid_pending--;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		lfsr_state  = 32'h85613ac9;
		inflight    = 0;
		vid_pending = 0;
		vid_idx     = 0;
		ready_drops = 0;
		checks      = 0;
		mismatches  = 0;
		failures    = 0;
		rst_n       = 1'b0;
		cpu_valid   = 1'b0;
		cpu_rnw     = 1'b1;
		cpu_addr    = '0;
		cpu_wdata   = '0;
		pg_wr       = 1'b0;
		pg_win      = '0;
		pg_val      = '0;
		line_start  = 1'b0;
		line_num    = '0;
		for (int w = 0; w < 4; w++)
			ref_page[w] = page_t'(w);
		build_table();

		repeat (8) @(posedge fclk);
		rst_n <= 1'b1;
		@(negedge fclk);
		checks += 3;
		if (cpu_ready !== 1'b1)
			report_mismatch("cpu_ready", 16'h1, 16'(cpu_ready));
		if (cpu_rdata_valid !== 1'b0)
			report_mismatch("cpu_rdata_valid", 16'h0, 16'(cpu_rdata_valid));
		if (pix_valid !== 1'b0)
			report_mismatch("pix_valid", 16'h0, 16'(pix_valid));

		foreach (steps[i])
		begin
			case (steps[i].kind)
				k_page:
					page_write(steps[i]);
				k_write:
				begin
					idle_cycles(int'(take_bits(2)));
					cpu_access(steps[i]);
				end
				k_read:
					cpu_access(steps[i]);
				default:
					start_line(steps[i]);
			endcase
		end
		drain();

		if (ready_drops == 0)
		begin
			$display("cpu_ready never dropped, back-pressure was not exercised");
			failures++;
		end

		$display("checks %0d, mismatches %0d, other failures %0d",
			checks, mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

/* source/zx_mem_top.sv */
`timescale 1ns/1ns

module zx_mem_top
	import zx_mem_pkg::*, zx_video_pkg::*;
(
	input  logic       fclk,
	input  logic       rst_n,

	// z80 side
	input  logic       cpu_valid,
	input  logic       cpu_rnw,
	input  cpu_addr_t  cpu_addr,
	input  logic [7:0] cpu_wdata,
	output logic       cpu_ready,
	output logic       cpu_rdata_valid,
	output logic [7:0] cpu_rdata,

	// page writes
	input  logic       pg_wr,
	input  logic [1:0] pg_win,
	input  page_t      pg_val,

	// video
	input  logic       line_start,
	input  line_t      line_num,
	output logic       pix_valid,
	output word_idx_t  pix_idx,
	output mem_word_t  pix_word
);

	logic     cpu_req_valid;
	mem_req_t cpu_req;
	logic     cpu_credit;
	mem_rsp_t cpu_rsp;

	logic     vid_req_valid;
	mem_req_t vid_req;
	logic     vid_credit;
	mem_rsp_t vid_rsp;

	logic     st_valid;
	mem_req_t st_req;
	src_t     st_src;
	mem_rsp_t st_rsp;

	////////////////////////////////////////////////////////////////////////////
	// requesters
	////////////////////////////////////////////////////////////////////////////

	cpu_window_mapper mapper (
		.fclk(fclk), .rst_n(rst_n),
		.cpu_valid(cpu_valid), .cpu_rnw(cpu_rnw),
		.cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
		.pg_wr(pg_wr), .pg_win(pg_win), .pg_val(pg_val),
		.cpu_ready(cpu_ready),
		.req_valid(cpu_req_valid), .req(cpu_req),
		.credit(cpu_credit), .rsp(cpu_rsp),
		.cpu_rdata_valid(cpu_rdata_valid), .cpu_rdata(cpu_rdata)
	);

	video_line_fetch fetcher (
		.fclk(fclk), .rst_n(rst_n),
		.line_start(line_start), .line_num(line_num),
		.req_valid(vid_req_valid), .req(vid_req),
		.credit(vid_credit), .rsp(vid_rsp),
		.pix_valid(pix_valid), .pix_idx(pix_idx), .pix_word(pix_word)
	);

	////////////////////////////////////////////////////////////////////////////
	// shared dram
	////////////////////////////////////////////////////////////////////////////

	dram_slot_arbiter arbiter (
		.fclk(fclk), .rst_n(rst_n),
		.cpu_valid(cpu_req_valid), .cpu_req(cpu_req),
		.vid_valid(vid_req_valid), .vid_req(vid_req),
		.cpu_credit(cpu_credit), .vid_credit(vid_credit),
		.st_valid(st_valid), .st_req(st_req), .st_src(st_src),
		.st_rsp(st_rsp),
		.cpu_rsp(cpu_rsp), .vid_rsp(vid_rsp)
	);

	dram_store store (
		.fclk(fclk), .rst_n(rst_n),
		.st_valid(st_valid), .st_req(st_req), .st_src(st_src),
		.st_rsp(st_rsp)
	);

endmodule

/* source/dram_store.sv */
`timescale 1ns/1ns

module dram_store
	import zx_mem_pkg::*;
(
	input  logic     fclk,
	input  logic     rst_n,

	input  logic     st_valid,
	input  mem_req_t st_req,
	input  src_t     st_src,
	output mem_rsp_t st_rsp
);

	mem_word_t           mem [2**STORE_AW];
	logic [STORE_AW-1:0] waddr;
	logic                rd_go;

	// two-stage read pipeline
	logic                s1_valid;
	src_t                s1_src;
	mem_word_t           s1_data;
	logic                s2_valid;
	src_t                s2_src;
	mem_word_t           s2_data;

	// upper address bits alias
	assign waddr = st_req.addr[STORE_AW-1:0];
	assign rd_go = st_valid && st_req.rnw;

	always_ff @(posedge fclk)
	begin
		if (st_valid && !st_req.rnw)
		begin
			if (st_req.bsel[0])
				mem[waddr][7:0] <= st_req.wdata[7:0];
			if (st_req.bsel[1])
				mem[waddr][15:8] <= st_req.wdata[15:8];
		end
	end

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end
		else
		begin
			s1_valid <= rd_go;
			s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge fclk)
	begin
		if (rd_go)
		begin
			s1_data <= mem[waddr];
			s1_src  <= st_src;
		end
		if (s1_valid)
		begin
			s2_data <= s1_data;
			s2_src  <= s1_src;
		end
	end

	assign st_rsp = '{valid: s2_valid, src: s2_src, data: s2_data};

endmodule

/* source/dram_slot_arbiter.sv */
`timescale 1ns/1ns

module dram_slot_arbiter
	import zx_mem_pkg::*;
(
	input  logic     fclk,
	input  logic     rst_n,

	// requesters
	input  logic     cpu_valid,
	input  mem_req_t cpu_req,
	input  logic     vid_valid,
	input  mem_req_t vid_req,
	output logic     cpu_credit,
	output logic     vid_credit,

	// store side
	output logic     st_valid,
	output mem_req_t st_req,
	output src_t     st_src,
	input  mem_rsp_t st_rsp,

	// routed read data
	output mem_rsp_t cpu_rsp,
	output mem_rsp_t vid_rsp
);

	// queue index follows src_t: 0 is cpu, 1 is video
	logic [1:0]           in_valid;
	mem_req_t             in_req [2];
	logic [1:0]           pop;

	mem_req_t             q_mem [2][REQ_CREDITS];
	logic [REQ_PTR_W-1:0] q_wp [2];
	logic [REQ_PTR_W-1:0] q_rp [2];
	credit_t              q_cnt [2];

	logic                 vid_pick;
	logic                 cpu_pick;

	assign in_valid  = {vid_valid, cpu_valid};
	assign in_req[0] = cpu_req;
	assign in_req[1] = vid_req;

	////////////////////////////////////////////////////////////////////////////
	// slot choice, video first
	////////////////////////////////////////////////////////////////////////////

	assign vid_pick = (q_cnt[1] != '0);
	assign cpu_pick = !vid_pick && (q_cnt[0] != '0);

	assign st_valid = vid_pick || cpu_pick;
	assign st_src   = vid_pick ? src_video : src_cpu;
	assign st_req   = vid_pick ? q_mem[1][q_rp[1]] : q_mem[0][q_rp[0]];

	assign pop = {vid_pick, cpu_pick};

	// one credit back per issued entry
	assign cpu_credit = pop[0];
	assign vid_credit = pop[1];

	////////////////////////////////////////////////////////////////////////////
	// request queues
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			for (int s = 0; s < 2; s++)
			begin
				q_wp[s]  <= '0;
				q_rp[s]  <= '0;
				q_cnt[s] <= '0;
			end
		end
		else
		begin
			for (int s = 0; s < 2; s++)
			begin
				if (in_valid[s])
					q_wp[s] <= q_wp[s] + 1'b1;
				if (pop[s])
					q_rp[s] <= q_rp[s] + 1'b1;
				q_cnt[s] <= q_cnt[s] + credit_t'(in_valid[s]) - credit_t'(pop[s]);
			end
		end
	end

	// credits keep the queues from overflowing
	always_ff @(posedge fclk)
	begin
		for (int s = 0; s < 2; s++)
		begin
			if (in_valid[s])
				q_mem[s][q_wp[s]] <= in_req[s];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// response routing by tag
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		cpu_rsp       = st_rsp;
		vid_rsp       = st_rsp;
		cpu_rsp.valid = st_rsp.valid && (st_rsp.src == src_cpu);
		vid_rsp.valid = st_rsp.valid && (st_rsp.src == src_video);
	end

endmodule

/* source/video_line_fetch.sv */
`timescale 1ns/1ns

module video_line_fetch
	import zx_mem_pkg::*, zx_video_pkg::*;
(
	input  logic      fclk,
	input  logic      rst_n,

	input  logic      line_start,
	input  line_t     line_num,

	// toward the arbiter
	output logic      req_valid,
	output mem_req_t  req,
	input  logic      credit,
	input  mem_rsp_t  rsp,

	// screen words
	output logic      pix_valid,
	output word_idx_t pix_idx,
	output mem_word_t pix_word
);

	fetch_state_t           state;
	line_t                  line_q;
	logic [FETCH_CNT_W-1:0] iss_cnt;
	word_idx_t              ret_idx;
	credit_t                credits;
	logic [WIN_OFF_W-1:0]   line_off;
	logic                   issue_left;

	assign issue_left = (iss_cnt < FETCH_CNT_W'(WORDS_PER_LINE));
	assign req_valid  = (state == fs_issue) && issue_left && (credits != '0);

	// word offset of the next read inside the screen page
	assign line_off = WIN_OFF_W'(line_q) * WIN_OFF_W'(WORDS_PER_LINE) + WIN_OFF_W'(iss_cnt);

	always_comb
	begin
		req.rnw   = 1'b1;
		req.addr  = {VIDEO_PAGE, line_off};
		req.wdata = '0;
		req.bsel  = 2'b11;
	end

	////////////////////////////////////////////////////////////////////////////
	// burst control
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			state   <= fs_idle;
			iss_cnt <= '0;
			ret_idx <= '0;
		end
		else
		begin
			case (state)
				fs_idle:
				begin
					if (line_start)
					begin
						state   <= fs_issue;
						iss_cnt <= '0;
						ret_idx <= '0;
					end
				end
				fs_issue:
				begin
					if (req_valid)
						iss_cnt <= iss_cnt + 1'b1;
					if (rsp.valid)
					begin
						ret_idx <= ret_idx + 1'b1;
						// last word back, burst done
						if (ret_idx == word_idx_t'(WORDS_PER_LINE - 1))
							state <= fs_idle;
					end
				end
				default:
					state <= fs_idle;
			endcase
		end
	end

	always_ff @(posedge fclk)
	begin
		if (state == fs_idle && line_start)
			line_q <= line_num;
	end

	// credit counter
	always_ff @(posedge fclk)
	begin
		if (!rst_n)
			credits <= credit_t'(REQ_CREDITS);
		else
			credits <= credits - credit_t'(req_valid) + credit_t'(credit);
	end

	assign pix_valid = rsp.valid;
	assign pix_idx   = ret_idx;
	assign pix_word  = rsp.data;

endmodule

/* source/cpu_window_mapper.sv */
`timescale 1ns/1ns

module cpu_window_mapper
	import zx_mem_pkg::*;
(
	input  logic       fclk,
	input  logic       rst_n,

	// z80 byte access
	input  logic       cpu_valid,
	input  logic       cpu_rnw,
	input  cpu_addr_t  cpu_addr,
	input  logic [7:0] cpu_wdata,

	// page registers
	input  logic       pg_wr,
	input  logic [1:0] pg_win,
	input  page_t      pg_val,

	output logic       cpu_ready,

	// toward the arbiter
	output logic       req_valid,
	output mem_req_t   req,
	input  logic       credit,
	input  mem_rsp_t   rsp,

	output logic       cpu_rdata_valid,
	output logic [7:0] cpu_rdata
);

	page_t                win_page [4];
	credit_t              credits;
	logic                 accept;
	mem_req_t             mapped;

	// address bit 0 of outstanding reads, oldest at lane_rp
	// two can wait for issue and two more sit in the store pipeline
	logic                 lane_q [2**(REQ_PTR_W+1)];
	logic [REQ_PTR_W:0]   lane_wp;
	logic [REQ_PTR_W:0]   lane_rp;

	assign cpu_ready = (credits != '0);
	assign accept    = cpu_valid && cpu_ready;

	////////////////////////////////////////////////////////////////////////////
	// window mapping
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 4; i++)
				win_page[i] <= page_t'(i);
		end
		else if (pg_wr)
			win_page[pg_win] <= pg_val;
	end

	always_comb
	begin
		mapped.rnw   = cpu_rnw;
		mapped.addr  = {win_page[cpu_addr[15:14]], cpu_addr[13:1]};
		// byte goes to both halves, lane picked by bsel
		mapped.wdata = {cpu_wdata, cpu_wdata};
		if (cpu_rnw)
			mapped.bsel = 2'b11;
		else
			mapped.bsel = cpu_addr[0] ? 2'b10 : 2'b01;
	end

	////////////////////////////////////////////////////////////////////////////
	// request stage and credits
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			req_valid <= 1'b0;
			credits   <= credit_t'(REQ_CREDITS);
		end
		else
		begin
			req_valid <= accept;
			credits   <= credits - credit_t'(accept) + credit_t'(credit);
		end
	end

	always_ff @(posedge fclk)
	begin
		if (accept)
			req <= mapped;
	end

	// read lane queue
	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			lane_wp <= '0;
			lane_rp <= '0;
		end
		else
		begin
			if (accept && cpu_rnw)
				lane_wp <= lane_wp + 1'b1;
			if (rsp.valid)
				lane_rp <= lane_rp + 1'b1;
		end
	end

	always_ff @(posedge fclk)
	begin
		if (accept && cpu_rnw)
			lane_q[lane_wp] <= cpu_addr[0];
	end

	assign cpu_rdata_valid = rsp.valid;
	assign cpu_rdata       = lane_q[lane_rp] ? rsp.data[15:8] : rsp.data[7:0];

endmodule

/* source/zx_video_pkg.sv */
package zx_video_pkg;

	// screen lives in this page
	localparam logic [7:0] VIDEO_PAGE = 8'd5;

	localparam int WORDS_PER_LINE = 16;

	// issue counter must reach WORDS_PER_LINE itself
	localparam int FETCH_CNT_W = $clog2(WORDS_PER_LINE) + 1;

	typedef logic [7:0] line_t;
	typedef logic [3:0] word_idx_t;

	typedef enum logic {
		fs_idle,
		fs_issue
	} fetch_state_t;

endpackage

/* source/zx_mem_pkg.sv */
package zx_mem_pkg;

	////////////////////////////////////////////////////////////////////////////
	// sizes
	////////////////////////////////////////////////////////////////////////////

	// queue depth per source, also the starting credit count
	localparam int REQ_CREDITS = 2;
	localparam int REQ_PTR_W   = $clog2(REQ_CREDITS);
	localparam int CREDIT_W    = $clog2(REQ_CREDITS + 1);

	// word-address bits decoded by the store, the rest alias
	localparam int STORE_AW    = 12;

	// word offset inside a 16 KB window
	localparam int WIN_OFF_W   = 13;

	////////////////////////////////////////////////////////////////////////////
	// bus types
	////////////////////////////////////////////////////////////////////////////

	typedef logic [15:0]                      cpu_addr_t;
	typedef logic [7:0]                       page_t;
	typedef logic [8+WIN_OFF_W-1:0]           phys_addr_t;
	typedef logic [15:0]                      mem_word_t;
	typedef logic [1:0]                       bsel_t;
	typedef logic [CREDIT_W-1:0]              credit_t;

	typedef enum logic {src_cpu = 1'b0, src_video = 1'b1} src_t;

	typedef struct packed {
		logic       rnw;
		phys_addr_t addr;
		mem_word_t  wdata;
		bsel_t      bsel;
	} mem_req_t;

	typedef struct packed {
		logic      valid;
		src_t      src;
		mem_word_t data;
	} mem_rsp_t;

endpackage
